// File: res_pkg.sv
//##############################
// Resolver converter package
// Serial frame, pin codes, sequencer timing and the captured word
//##############################
package res_pkg;

    // One normal-mode read frame is a data word followed by the fault byte
    localparam int FRAME_BITS = 24;
    localparam int DATA_BITS  = 16;
    localparam int FAULT_BITS = 8;
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);

    // A1/A0 address pin code
    typedef enum logic [1:0] {
        MODE_POS = 2'b00,
        MODE_VEL = 2'b01
    } res_mode_e;

    // RE1/RE0 resolution pin code
    typedef enum logic [1:0] {
        RES_10 = 2'b00,
        RES_12 = 2'b01,
        RES_14 = 2'b10,
        RES_16 = 2'b11
    } res_code_e;

    // Sequencer timing in sclk cycles
    localparam int ADDR_SETUP_CYC = 2;
    localparam int SAMPLE_LOW_CYC = 4;
    localparam int SETTLE_CYC     = 4;
    localparam int DLY_CNT_W      = 3;

    // Sequencer state codes
    localparam logic [2:0] SEQ_IDLE   = 3'd0;
    localparam logic [2:0] SEQ_ADDR   = 3'd1;
    localparam logic [2:0] SEQ_SAMPLE = 3'd2;
    localparam logic [2:0] SEQ_SETTLE = 3'd3;
    localparam logic [2:0] SEQ_FRAME  = 3'd4;
    localparam logic [2:0] SEQ_DONE   = 3'd5;

    // Data word reads as an angle or as a two's complement velocity
    typedef union packed {
        logic        [DATA_BITS-1:0] pos;
        logic signed [DATA_BITS-1:0] vel;
    } res_word_u;

endpackage

// File: bus_pkg.sv
//##############################
// Host register map
// Addresses, field positions and reset values
//##############################
package bus_pkg;

    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 16;
    localparam int CLKDIV_W   = 8;

    // Register addresses
    localparam logic [REG_ADDR_W-1:0] ADDR_CTRL   = 4'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_CLKDIV = 4'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_RES    = 4'd2;

    // CTRL fields
    localparam int CTRL_VEL_BIT = 0;
    localparam int CTRL_RST_BIT = 1;

    // Half period of the bit clock minus one
    localparam logic [CLKDIV_W-1:0] CLKDIV_RST = 8'd3;

    // Full resolution out of reset
    localparam res_pkg::res_code_e RES_RST = res_pkg::RES_16;

endpackage

// File: res_ifs.sv
//##############################
// Internal links of the resolver controller
//##############################
`timescale 1ns/10ps

// Static configuration levels from the register block
interface res_cfg_if;
    res_pkg::res_mode_e             mode;
    res_pkg::res_code_e             res;
    logic [bus_pkg::CLKDIV_W-1:0]   clkdiv;
    logic                           chip_reset;

    // Register block owns every level
    modport src (
        output mode,
        output res,
        output clkdiv,
        output chip_reset
    );

    // Sequencer picks address code and masking
    modport seq (
        input mode,
        input res
    );

    // Frame engine only needs the bit clock divider
    modport spi (
        input clkdiv
    );
endinterface

// Frame request and result between sequencer and frame engine
interface res_xfer_if;
    logic                           req;
    logic                           busy;
    logic                           done;
    logic [res_pkg::FRAME_BITS-1:0] frame;

    modport ctl (
        output req,
        input  busy,
        input  done,
        input  frame
    );

    modport eng (
        input  req,
        output busy,
        output done,
        output frame
    );
endinterface

// File: ad2s1210_regs.sv
//##############################
// Resolver configuration registers
// Stores mode, divider and resolution, drives static pins
//##############################
`timescale 1ns/10ps

module ad2s1210_regs (
    input  logic                           sclk,
    input  logic                           rst_n,
    input  logic                           reg_wr,
    input  logic [bus_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [bus_pkg::REG_DATA_W-1:0] reg_wdata,
    res_cfg_if.src                         cfg,
    output logic [1:0]                     res_re,
    output logic                           res_reset_n
);

    // CTRL register fields
    logic                           ctrl_vel;
    logic                           ctrl_rst;
    // Divider and resolution registers
    logic [bus_pkg::CLKDIV_W-1:0]   clkdiv_q;
    res_pkg::res_code_e             res_q;

    // Write decode, unmapped addresses fall through
    always_ff @(posedge sclk) begin
        if (!rst_n) begin
            ctrl_vel <= 1'b0;
            ctrl_rst <= 1'b0;
            clkdiv_q <= bus_pkg::CLKDIV_RST;
            res_q    <= bus_pkg::RES_RST;
        end else if (reg_wr) begin
            case (reg_addr)
                bus_pkg::ADDR_CTRL: begin
                    ctrl_vel <= reg_wdata[bus_pkg::CTRL_VEL_BIT];
                    ctrl_rst <= reg_wdata[bus_pkg::CTRL_RST_BIT];
                end
                bus_pkg::ADDR_CLKDIV: begin
                    clkdiv_q <= reg_wdata[bus_pkg::CLKDIV_W-1:0];
                end
                bus_pkg::ADDR_RES: begin
                    res_q <= res_pkg::res_code_e'(reg_wdata[1:0]);
                end
                default: begin
                end
            endcase
        end
    end

    // Levels shared with sequencer and frame engine
    assign cfg.mode       = ctrl_vel ? res_pkg::MODE_VEL : res_pkg::MODE_POS;
    assign cfg.res        = res_q;
    assign cfg.clkdiv     = clkdiv_q;
    assign cfg.chip_reset = ctrl_rst;

    // RE pins follow the stored code directly
    assign res_re      = cfg.res;
    // Converter reset pin is active low
    assign res_reset_n = ~cfg.chip_reset;

endmodule

// File: ad2s1210_spi.sv
//##############################
// Serial frame engine
// WR framing, bit clock and 24 bit MSB first capture
//##############################
`timescale 1ns/10ps

module ad2s1210_spi (
    input  logic    sclk,
    input  logic    rst_n,
    res_cfg_if.spi  cfg,
    res_xfer_if.eng xfer,
    output logic    res_wr_n,
    output logic    res_sck,
    input  logic    res_miso
);

    logic [bus_pkg::CLKDIV_W-1:0]     div_q;
    logic [bus_pkg::CLKDIV_W-1:0]     hcnt;
    logic [res_pkg::BIT_CNT_W-1:0]    bit_cnt;
    logic [res_pkg::FRAME_BITS-1:0]   shreg;
    logic                             busy_q;
    logic                             done_q;
    // Half-period boundary while a frame runs
    logic                             tick;
    logic                             last;
    logic                             rise;

    assign tick = busy_q && (hcnt == '0);
    // All bits taken, next boundary closes the frame
    assign last = (bit_cnt == res_pkg::BIT_CNT_W'(res_pkg::FRAME_BITS));
    // SCK going low to high on this edge
    assign rise = tick && !last && !res_sck;

    always_ff @(posedge sclk) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            res_wr_n <= 1'b1;
            res_sck  <= 1'b1;
            div_q    <= '0;
            hcnt     <= '0;
            bit_cnt  <= '0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                // Divider latched once per frame
                if (xfer.req) begin
                    busy_q   <= 1'b1;
                    res_wr_n <= 1'b0;
                    div_q    <= cfg.clkdiv;
                    hcnt     <= cfg.clkdiv;
                    bit_cnt  <= '0;
                end
            end else if (!tick) begin
                hcnt <= hcnt - 1'b1;
            end else begin
                hcnt <= div_q;
                if (last) begin
                    // SCK already back high, release WR
                    res_wr_n <= 1'b1;
                    busy_q   <= 1'b0;
                    done_q   <= 1'b1;
                end else begin
                    res_sck <= ~res_sck;
                    if (rise)
                        bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // MSB first, one bit per SCK rising edge
    always_ff @(posedge sclk) begin
        if (rise)
            shreg <= {shreg[res_pkg::FRAME_BITS-2:0], res_miso};
    end

    assign xfer.busy  = busy_q;
    assign xfer.done  = done_q;
    assign xfer.frame = shreg;

endmodule

// File: ad2s1210_seq.sv
//##############################
// Acquisition sequencer
// Address setup, SAMPLE pulse, frame request and masking
//##############################
`timescale 1ns/10ps

module ad2s1210_seq (
    input  logic                            sclk,
    input  logic                            rst_n,
    input  logic                            start,
    res_cfg_if.seq                          cfg,
    res_xfer_if.ctl                         xfer,
    output logic [1:0]                      res_a,
    output logic                            res_sample_n,
    output logic                            busy,
    output logic [res_pkg::DATA_BITS-1:0]   data,
    output logic [res_pkg::FAULT_BITS-1:0]  fault,
    output logic                            data_valid
);

    logic [2:0]                         state;
    logic [res_pkg::DLY_CNT_W-1:0]      cnt;
    logic                               req_q;
    // Resolution held for the whole read
    res_pkg::res_code_e                 res_q;
    res_pkg::res_word_u                 word;
    logic [2:0]                         drop;
    logic [res_pkg::DATA_BITS-1:0]      mask;
    logic signed [res_pkg::DATA_BITS-1:0] vel_trunc;
    logic [res_pkg::DATA_BITS-1:0]      word_masked;

    always_ff @(posedge sclk) begin
        if (!rst_n) begin
            state        <= res_pkg::SEQ_IDLE;
            cnt          <= '0;
            req_q        <= 1'b0;
            res_a        <= res_pkg::MODE_POS;
            res_q        <= res_pkg::RES_16;
            res_sample_n <= 1'b1;
        end else begin
            req_q <= 1'b0;
            case (state)
                // Result cycle also accepts a new start
                res_pkg::SEQ_IDLE, res_pkg::SEQ_DONE: begin
                    if (start) begin
                        state <= res_pkg::SEQ_ADDR;
                        res_a <= cfg.mode;
                        res_q <= cfg.res;
                        cnt   <= res_pkg::DLY_CNT_W'(res_pkg::ADDR_SETUP_CYC - 1);
                    end else begin
                        state <= res_pkg::SEQ_IDLE;
                    end
                end
                res_pkg::SEQ_ADDR: begin
                    if (cnt == '0) begin
                        res_sample_n <= 1'b0;
                        state        <= res_pkg::SEQ_SAMPLE;
                        cnt <= res_pkg::DLY_CNT_W'(res_pkg::SAMPLE_LOW_CYC - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                res_pkg::SEQ_SAMPLE: begin
                    if (cnt == '0) begin
                        res_sample_n <= 1'b1;
                        state        <= res_pkg::SEQ_SETTLE;
                        cnt <= res_pkg::DLY_CNT_W'(res_pkg::SETTLE_CYC - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                res_pkg::SEQ_SETTLE: begin
                    // Engine must be idle before a new request
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (!xfer.busy) begin
                        req_q <= 1'b1;
                        state <= res_pkg::SEQ_FRAME;
                    end
                end
                res_pkg::SEQ_FRAME: begin
                    if (xfer.done)
                        state <= res_pkg::SEQ_DONE;
                end
                default: state <= res_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Resolution mask, low bits are meaningless below 16 bits
    always_comb begin
        word = xfer.frame[res_pkg::FRAME_BITS-1 -: res_pkg::DATA_BITS];
        case (res_q)
            res_pkg::RES_10: drop = 3'd6;
            res_pkg::RES_12: drop = 3'd4;
            res_pkg::RES_14: drop = 3'd2;
            default:         drop = 3'd0;
        endcase
        mask      = {res_pkg::DATA_BITS{1'b1}} << drop;
        // Arithmetic shift keeps the velocity sign
        vel_trunc = word.vel >>> drop;
        if (res_a == res_pkg::MODE_VEL)
            word_masked = vel_trunc <<< drop;
        else
            word_masked = word.pos & mask;
    end

    // Result words
    always_ff @(posedge sclk) begin
        if (state == res_pkg::SEQ_FRAME && xfer.done) begin
            data  <= word_masked;
            fault <= xfer.frame[res_pkg::FAULT_BITS-1:0];
        end
    end

    assign xfer.req   = req_q;
    assign data_valid = (state == res_pkg::SEQ_DONE);
    assign busy       = (state != res_pkg::SEQ_IDLE) && (state != res_pkg::SEQ_DONE);

endmodule

// File: ad2s1210_if.sv
//##############################
// Resolver controller top
// Registers, sequencer and frame engine
//##############################
`timescale 1ns/10ps

module ad2s1210_if (
    input  logic                            sclk,
    input  logic                            rst_n,
    // Host register bus
    input  logic                            reg_wr,
    input  logic [bus_pkg::REG_ADDR_W-1:0]  reg_addr,
    input  logic [bus_pkg::REG_DATA_W-1:0]  reg_wdata,
    input  logic                            start,
    // Read results
    output logic                            busy,
    output logic [res_pkg::DATA_BITS-1:0]   data,
    output logic [res_pkg::FAULT_BITS-1:0]  fault,
    output logic                            data_valid,
    // Converter pins
    output logic [1:0]                      res_a,
    output logic [1:0]                      res_re,
    output logic                            res_sample_n,
    output logic                            res_reset_n,
    output logic                            res_wr_n,
    output logic                            res_sck,
    input  logic                            res_miso
);

    res_cfg_if  cfg ();
    res_xfer_if xfer ();

    ad2s1210_regs u_regs (
        .sclk        (sclk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .cfg         (cfg.src),
        .res_re      (res_re),
        .res_reset_n (res_reset_n)
    );

    ad2s1210_seq u_seq (
        .sclk         (sclk),
        .rst_n        (rst_n),
        .start        (start),
        .cfg          (cfg.seq),
        .xfer         (xfer.ctl),
        .res_a        (res_a),
        .res_sample_n (res_sample_n),
        .busy         (busy),
        .data         (data),
        .fault        (fault),
        .data_valid   (data_valid)
    );

    ad2s1210_spi u_spi (
        .sclk     (sclk),
        .rst_n    (rst_n),
        .cfg      (cfg.spi),
        .xfer     (xfer.eng),
        .res_wr_n (res_wr_n),
        .res_sck  (res_sck),
        .res_miso (res_miso)
    );

endmodule

// File: ad2s1210_asserts.sv
//##############################
// Converter pin protocol checks
//##############################
`timescale 1ns/10ps

module ad2s1210_asserts (
    input logic sclk,
    input logic rst_n,
    input logic res_sck,
    input logic res_wr_n,
    input logic res_sample_n,
    input logic data_valid,
    input logic busy
);

    // Failure count, watched by the testbench
    int assert_fails = 0;

    // SCK moves only inside a frame
    sck_in_frame: assert property (@(posedge sclk) disable iff (!rst_n)
        $changed(res_sck) |-> (!res_wr_n && !$past(res_wr_n)))
    else begin
        assert_fails++;
        $error("res_sck toggled outside a frame");
    end

    // No frame while the converter is sampling
    wr_vs_sample: assert property (@(posedge sclk) disable iff (!rst_n)
        !res_sample_n |-> res_wr_n)
    else begin
        assert_fails++;
        $error("res_wr_n low during SAMPLE low");
    end

    // Result strobe is a single cycle
    valid_width: assert property (@(posedge sclk) disable iff (!rst_n)
        data_valid |=> !data_valid)
    else begin
        assert_fails++;
        $error("data_valid wider than one cycle");
    end

    // Busy drops exactly with the result strobe
    busy_end: assert property (@(posedge sclk) disable iff (!rst_n)
        $fell(busy) |-> $rose(data_valid))
    else begin
        assert_fails++;
        $error("busy fell without data_valid");
    end

endmodule

bind ad2s1210_if ad2s1210_asserts u_asserts (
    .sclk         (sclk),
    .rst_n        (rst_n),
    .res_sck      (res_sck),
    .res_wr_n     (res_wr_n),
    .res_sample_n (res_sample_n),
    .data_valid   (data_valid),
    .busy         (busy)
);

// File: ad2s1210_tb.sv
//##############################
// Resolver controller testbench
// Converter model, reference check, watchdog
//##############################
`timescale 1ns/10ps

module ad2s1210_tb;

    logic                           sclk;
    logic                           rst_n;
    logic                           reg_wr;
    logic [bus_pkg::REG_ADDR_W-1:0] reg_addr;
    logic [bus_pkg::REG_DATA_W-1:0] reg_wdata;
    logic                           start;
    logic                           busy;
    logic [15:0]                    data;
    logic [7:0]                     fault;
    logic                           data_valid;
    logic [1:0]                     res_a;
    logic [1:0]                     res_re;
    logic                           res_sample_n;
    logic                           res_reset_n;
    logic                           res_wr_n;
    logic                           res_sck;
    logic                           res_miso;

    // Converter model state
    logic [31:0] rng;
    logic [23:0] model_word;
    int          bit_idx;
    int          rise_cnt;
    logic [1:0]  sample_a;
    // Reads in flight in arrival order
    logic [23:0] frame_q[$];
    logic [1:0]  mode_q[$];
    logic [1:0]  res_q[$];
    int          accepted_cnt;
    int          valid_cnt;
    int          errors;
    // Shadow of the host registers
    logic [1:0]  cur_mode;
    logic [1:0]  cur_res;
    logic [23:0] exp_word;
    int          div_list[3] = '{0, 3, 7};

    ad2s1210_if UUT (
        .sclk         (sclk),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .start        (start),
        .busy         (busy),
        .data         (data),
        .fault        (fault),
        .data_valid   (data_valid),
        .res_a        (res_a),
        .res_re       (res_re),
        .res_sample_n (res_sample_n),
        .res_reset_n  (res_reset_n),
        .res_wr_n     (res_wr_n),
        .res_sck      (res_sck),
        .res_miso     (res_miso)
    );

    initial begin
        sclk = 1'b0;
        forever #4 sclk = ~sclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected {data, fault} of one frame
    function automatic logic [23:0] ref_result(input logic [23:0] frame,
                                               input logic [1:0] mode,
                                               input logic [1:0] res);
        logic [15:0] word;
        logic [15:0] keep;
        int          drop;
        word = frame[23:8];
        case (res)
            res_pkg::RES_10: drop = 6;
            res_pkg::RES_12: drop = 4;
            res_pkg::RES_14: drop = 2;
            default:         drop = 0;
        endcase
        if (mode == res_pkg::MODE_VEL) begin
            // Only the low field is cleared so the sign bits stay
            for (int i = 0; i < drop; i++)
                word[i] = 1'b0;
        end else begin
            keep = 16'hffff << drop;
            word = word & keep;
        end
        return {word, frame[7:0]};
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [15:0] wdata);
        @(posedge sclk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = wdata;
        @(posedge sclk);
        #1;
        reg_wr = 1'b0;
    endtask

    // Start strobe booked as a read only when no read is pending
    task automatic pulse_start();
        logic pending;
        @(posedge sclk);
        #1;
        pending = (accepted_cnt != valid_cnt);
        compare("busy", busy, pending);
        start = 1'b1;
        if (!pending) begin
            accepted_cnt++;
            mode_q.push_back(cur_mode);
            res_q.push_back(cur_res);
        end
        @(posedge sclk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_results();
        while (valid_cnt != accepted_cnt)
            @(posedge sclk);
    endtask

    task automatic run_reads(input int n);
        for (int i = 0; i < n; i++) begin
            pulse_start();
            wait_results();
        end
    endtask

    // Converter model loads a new word on each frame start
    always @(negedge res_wr_n) begin
        rng        = xorshift32(rng);
        model_word = rng[23:0];
        bit_idx    = 23;
        rise_cnt   = 0;
        frame_q.push_back(model_word);
        #1 res_miso = model_word[23];
    end

    always @(posedge res_sck) begin
        if (!res_wr_n)
            rise_cnt++;
    end

    // MSB stays until the first sample and then shifts on each falling edge
    always @(negedge res_sck) begin
        if (!res_wr_n && rise_cnt != 0) begin
            bit_idx--;
            #1 res_miso = model_word[bit_idx];
        end
    end

    always @(negedge res_sample_n)
        sample_a = res_a;

    // Result checker
    always @(negedge sclk) begin
        if (rst_n && data_valid) begin
            if (frame_q.size() == 0 || mode_q.size() == 0)
                abort_run("data_valid seen with no read pending");
            exp_word = ref_result(frame_q.pop_front(), mode_q[0], res_q[0]);
            compare("data", data, exp_word[23:8]);
            compare("fault", fault, exp_word[7:0]);
            compare("res_sck rises", rise_cnt, 24);
            compare("res_a at sample", sample_a, mode_q.pop_front());
            void'(res_q.pop_front());
            valid_cnt++;
        end
    end

    // Bound protocol assertions on the converter pins
    always @(negedge sclk) begin
        if (UUT.u_asserts.assert_fails != 0)
            abort_run("protocol assertion failed on the converter pins");
    end

    // Watchdog sized for 100 reads at the slowest divider
    initial begin
        int read_cyc;
        read_cyc = res_pkg::ADDR_SETUP_CYC + res_pkg::SAMPLE_LOW_CYC
                 + res_pkg::SETTLE_CYC + 4 + (2 * res_pkg::FRAME_BITS + 2) * 8;
        #(read_cyc * 100 * 8);
        abort_run("watchdog expired before the tests completed");
    end

    initial begin
        rst_n        = 1'b0;
        reg_wr       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        start        = 1'b0;
        res_miso     = 1'b0;
        rng          = 32'd81;
        accepted_cnt = 0;
        valid_cnt    = 0;
        errors       = 0;
        cur_mode     = res_pkg::MODE_POS;
        cur_res      = res_pkg::RES_16;
        repeat (8) @(posedge sclk);
        #1 rst_n = 1'b1;
        @(negedge sclk);
        // Idle pin levels out of reset
        compare("res_wr_n", res_wr_n, 1);
        compare("res_sck", res_sck, 1);
        compare("res_sample_n", res_sample_n, 1);
        compare("res_reset_n", res_reset_n, 1);
        compare("res_re", res_re, 2'b11);
        compare("busy", busy, 0);
        compare("data_valid", data_valid, 0);
        // Position reads at full resolution
        run_reads(20);
        // Velocity reads over every resolution
        write_reg(bus_pkg::ADDR_CTRL, 16'h0001);
        cur_mode = res_pkg::MODE_VEL;
        for (int r = 0; r < 4; r++) begin
            write_reg(bus_pkg::ADDR_RES, 16'(r));
            cur_res = 2'(r);
            compare("res_re", res_re, r);
            run_reads(3);
        end
        // Divider sweep in position mode
        write_reg(bus_pkg::ADDR_CTRL, 16'h0000);
        cur_mode = res_pkg::MODE_POS;
        foreach (div_list[d]) begin
            write_reg(bus_pkg::ADDR_CLKDIV, 16'(div_list[d]));
            run_reads(5);
        end
        // Starts during a read are dropped
        pulse_start();
        pulse_start();
        pulse_start();
        wait_results();
        repeat (40) @(posedge sclk);
        compare("data_valid count", valid_cnt, accepted_cnt);
        // Converter reset pin
        write_reg(bus_pkg::ADDR_CTRL, 16'h0002);
        compare("res_reset_n", res_reset_n, 0);
        write_reg(bus_pkg::ADDR_CTRL, 16'h0000);
        compare("res_reset_n", res_reset_n, 1);
        compare("pending frames", frame_q.size(), 0);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
res_pkg.sv
bus_pkg.sv
res_ifs.sv
ad2s1210_regs.sv
ad2s1210_spi.sv
ad2s1210_seq.sv
ad2s1210_if.sv
ad2s1210_asserts.sv
ad2s1210_tb.sv

// File: Bender.yml
package:
  name: ad2s1210_ctrl

sources:
  # Packages first, bus_pkg uses res_pkg
  - res_pkg.sv
  - bus_pkg.sv
  - res_ifs.sv
  - ad2s1210_regs.sv
  - ad2s1210_spi.sv
  - ad2s1210_seq.sv
  - ad2s1210_if.sv
  - target: test
    files:
      - ad2s1210_asserts.sv
      - ad2s1210_tb.sv
